// File: Makefile
.PHONY: all run clean

all: run

obj_dir/Vtb_mmu: project.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module tb_mmu -f project.f

run: obj_dir/Vtb_mmu
	./obj_dir/Vtb_mmu | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dmw_match.sv
`timescale 1ns/1ps

module dmw_match (
    input  logic           dmw0_plv0,
    input  logic           dmw0_plv3,
    input  logic           dmw1_plv0,
    input  logic           dmw1_plv3,
    input  logic [2:0]     dmw0_vseg,
    input  logic [2:0]     dmw0_pseg,
    input  logic [2:0]     dmw1_vseg,
    input  logic [2:0]     dmw1_pseg,
    input  logic [31:0]    s0_vaddr,
    input  logic [31:0]    s1_vaddr,
    input  mmu_pkg::plv_t  s0_plv,
    input  mmu_pkg::plv_t  s1_plv,
    output logic           s0_dmw_hit,
    output logic           s1_dmw_hit,
    output logic [31:0]    s0_dmw_paddr,
    output logic [31:0]    s1_dmw_paddr
);

    import mmu_pkg::*;

    logic s0_win0;
    logic s0_win1;
    logic s1_win0;
    logic s1_win1;

    // Window enabled for this level and segment equal to vaddr[31:29]
    function automatic logic win_hit(
        input logic        en_plv0,
        input logic        en_plv3,
        input logic [2:0]  vseg,
        input logic [31:0] vaddr,
        input plv_t        plv
    );
        return ((en_plv0 && (plv == plv_kern)) || (en_plv3 && (plv == plv_user)))
               && (vseg == vaddr[31:29]);
    endfunction

    assign s0_win0 = win_hit(dmw0_plv0, dmw0_plv3, dmw0_vseg, s0_vaddr, s0_plv);
    assign s0_win1 = win_hit(dmw1_plv0, dmw1_plv3, dmw1_vseg, s0_vaddr, s0_plv);
    assign s1_win0 = win_hit(dmw0_plv0, dmw0_plv3, dmw0_vseg, s1_vaddr, s1_plv);
    assign s1_win1 = win_hit(dmw1_plv0, dmw1_plv3, dmw1_vseg, s1_vaddr, s1_plv);

    assign s0_dmw_hit = s0_win0 || s0_win1;
    assign s1_dmw_hit = s1_win0 || s1_win1;

    // Window 0 takes precedence when both match
    assign s0_dmw_paddr = {s0_win0 ? dmw0_pseg : dmw1_pseg, s0_vaddr[28:0]};
    assign s1_dmw_paddr = {s1_win0 ? dmw0_pseg : dmw1_pseg, s1_vaddr[28:0]};

endmodule

// File: exc_pkg.sv
package exc_pkg;

    // 7-bit code, zero means no exception
    typedef logic [6:0] exc_code_t;

    localparam exc_code_t exc_none = 7'h00;

    // Page invalid, split by access kind
    localparam exc_code_t exc_pil = 7'h01;
    localparam exc_code_t exc_pis = 7'h02;
    localparam exc_code_t exc_pif = 7'h03;

    // Store to a clean page
    localparam exc_code_t exc_pme = 7'h04;

    // Page privilege violation
    localparam exc_code_t exc_ppi = 7'h07;

    // Address errors, fetch and memory side share the ecode, bit 6 tells them apart
    localparam exc_code_t exc_adef = 7'h08;
    localparam exc_code_t exc_adem = 7'h48;

    // TLB refill
    localparam exc_code_t exc_tlbr = 7'h3f;

endpackage

// File: mmu_pkg.sv
package mmu_pkg;

    // TLB geometry
    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = 4;

    // 4 KB pages only, so page numbers are vaddr/paddr bits 31..12
    typedef logic [19:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;

    // Privilege levels the windows care about
    localparam plv_t plv_kern = 2'd0;
    localparam plv_t plv_user = 2'd3;

    // Access kind of a request
    typedef enum logic [1:0] {
        mem_load  = 2'd0,
        mem_store = 2'd1,
        mem_fetch = 2'd2
    } mem_type_t;

    // One TLB entry, one page per entry
    typedef struct packed {
        vppn_t vppn;
        asid_t asid;
        logic  g;
        logic  e;
        ppn_t  ppn;
        plv_t  plv;
        logic  v;
        logic  d;
    } tlb_entry_t;

endpackage

// File: mmu_sva.sv
`timescale 1ns/1ps

module mmu_sva (
    input logic               clk,
    input logic               reset,
    input logic               pg,
    input logic               s0_req,
    input logic               s1_req,
    input logic               s0_valid,
    input logic               s1_valid,
    input exc_pkg::exc_code_t s0_exception,
    input exc_pkg::exc_code_t s1_exception
);

    import exc_pkg::*;

    // One result pulse per request, exactly one cycle later
    a_s0_pulse: assert property (@(posedge clk) disable iff (reset) s0_req |=> s0_valid)
        else $error("s0_valid missing one cycle after s0_req");
    a_s0_quiet: assert property (@(posedge clk) disable iff (reset) !s0_req |=> !s0_valid)
        else $error("s0_valid without a request");
    a_s1_pulse: assert property (@(posedge clk) disable iff (reset) s1_req |=> s1_valid)
        else $error("s1_valid missing one cycle after s1_req");
    a_s1_quiet: assert property (@(posedge clk) disable iff (reset) !s1_req |=> !s1_valid)
        else $error("s1_valid without a request");

    // Synchronous reset clears both pulses from the first reset edge on
    a_reset: assert property (@(posedge clk) $past(reset) |-> !s0_valid && !s1_valid)
        else $error("valid high during reset");

    // Direct translation never faults
    a_s0_direct: assert property (@(posedge clk) disable iff (reset)
        s0_req && !pg |=> s0_exception == exc_none)
        else $error("s0 exception with paging off");
    a_s1_direct: assert property (@(posedge clk) disable iff (reset)
        s1_req && !pg |=> s1_exception == exc_none)
        else $error("s1 exception with paging off");

endmodule

bind mmu_top mmu_sva sva0 (
    .clk          (clk),
    .reset        (reset),
    .pg           (pg),
    .s0_req       (s0_req),
    .s1_req       (s1_req),
    .s0_valid     (s0_valid),
    .s1_valid     (s1_valid),
    .s0_exception (s0_exception),
    .s1_exception (s1_exception)
);

// File: mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pg,
    input  mmu_pkg::asid_t                asid,
    input  logic                          dmw0_plv0,
    input  logic                          dmw0_plv3,
    input  logic [2:0]                    dmw0_vseg,
    input  logic [2:0]                    dmw0_pseg,
    input  logic                          dmw1_plv0,
    input  logic                          dmw1_plv3,
    input  logic [2:0]                    dmw1_vseg,
    input  logic [2:0]                    dmw1_pseg,
    input  logic                          tlb_we,
    input  logic [mmu_pkg::tlb_idx_w-1:0] tlb_windex,
    input  mmu_pkg::tlb_entry_t           tlb_wentry,
    input  logic                          s0_req,
    input  logic [31:0]                   s0_vaddr,
    input  mmu_pkg::mem_type_t            s0_mem_type,
    input  mmu_pkg::plv_t                 s0_plv,
    input  logic                          s1_req,
    input  logic [31:0]                   s1_vaddr,
    input  mmu_pkg::mem_type_t            s1_mem_type,
    input  mmu_pkg::plv_t                 s1_plv,
    output logic                          s0_valid,
    output logic [31:0]                   s0_paddr,
    output exc_pkg::exc_code_t            s0_exception,
    output logic                          s1_valid,
    output logic [31:0]                   s1_paddr,
    output exc_pkg::exc_code_t            s1_exception
);

    logic        s0_dmw_hit;
    logic        s1_dmw_hit;
    logic [31:0] s0_dmw_paddr;
    logic [31:0] s1_dmw_paddr;

    tlb_search_if s0_tlb ();
    tlb_search_if s1_tlb ();

    // TLB search on the upper 20 address bits
    tlb_lookup u_tlb_lookup (
        .clk        (clk),
        .reset      (reset),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wentry (tlb_wentry),
        .asid       (asid),
        .s0_vppn    (s0_vaddr[31:12]),
        .s1_vppn    (s1_vaddr[31:12]),
        .s0_res     (s0_tlb),
        .s1_res     (s1_tlb)
    );

    dmw_match u_dmw_match (
        .dmw0_plv0    (dmw0_plv0),
        .dmw0_plv3    (dmw0_plv3),
        .dmw1_plv0    (dmw1_plv0),
        .dmw1_plv3    (dmw1_plv3),
        .dmw0_vseg    (dmw0_vseg),
        .dmw0_pseg    (dmw0_pseg),
        .dmw1_vseg    (dmw1_vseg),
        .dmw1_pseg    (dmw1_pseg),
        .s0_vaddr     (s0_vaddr),
        .s1_vaddr     (s1_vaddr),
        .s0_plv       (s0_plv),
        .s1_plv       (s1_plv),
        .s0_dmw_hit   (s0_dmw_hit),
        .s1_dmw_hit   (s1_dmw_hit),
        .s0_dmw_paddr (s0_dmw_paddr),
        .s1_dmw_paddr (s1_dmw_paddr)
    );

    tlb_exp_handler u_tlb_exp_handler (
        .clk          (clk),
        .reset        (reset),
        .pg           (pg),
        .s0_req       (s0_req),
        .s1_req       (s1_req),
        .s0_vaddr     (s0_vaddr),
        .s1_vaddr     (s1_vaddr),
        .s0_mem_type  (s0_mem_type),
        .s1_mem_type  (s1_mem_type),
        .s0_plv       (s0_plv),
        .s1_plv       (s1_plv),
        .s0_tlb       (s0_tlb),
        .s1_tlb       (s1_tlb),
        .s0_dmw_hit   (s0_dmw_hit),
        .s1_dmw_hit   (s1_dmw_hit),
        .s0_dmw_paddr (s0_dmw_paddr),
        .s1_dmw_paddr (s1_dmw_paddr),
        .s0_valid     (s0_valid),
        .s1_valid     (s1_valid),
        .s0_paddr     (s0_paddr),
        .s1_paddr     (s1_paddr),
        .s0_exception (s0_exception),
        .s1_exception (s1_exception)
    );

endmodule

// File: project.f
exc_pkg.sv
mmu_pkg.sv
tlb_search_if.sv
tlb_lookup.sv
dmw_match.sv
tlb_exp_handler.sv
mmu_top.sv
mmu_sva.sv
tb_mmu.sv

// File: tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;

    import mmu_pkg::*;
    import exc_pkg::*;

    typedef struct packed {
        logic [31:0] paddr;
        exc_code_t   exc;
    } result_t;

    logic                 clk;
    logic                 reset;
    logic                 pg;
    asid_t                asid;
    logic                 dmw0_plv0;
    logic                 dmw0_plv3;
    logic [2:0]           dmw0_vseg;
    logic [2:0]           dmw0_pseg;
    logic                 dmw1_plv0;
    logic                 dmw1_plv3;
    logic [2:0]           dmw1_vseg;
    logic [2:0]           dmw1_pseg;
    logic                 tlb_we;
    logic [tlb_idx_w-1:0] tlb_windex;
    tlb_entry_t           tlb_wentry;
    logic                 s0_req;
    logic [31:0]          s0_vaddr;
    mem_type_t            s0_mem_type;
    plv_t                 s0_plv;
    logic                 s1_req;
    logic [31:0]          s1_vaddr;
    mem_type_t            s1_mem_type;
    plv_t                 s1_plv;
    logic                 s0_valid;
    logic [31:0]          s0_paddr;
    exc_code_t            s0_exception;
    logic                 s1_valid;
    logic [31:0]          s1_paddr;
    exc_code_t            s1_exception;

    // Reference copy of the TLB and the results still in flight
    tlb_entry_t  model_tlb [tlb_num];
    result_t     exp_q0 [$];
    result_t     exp_q1 [$];
    logic        sent0_q;
    logic        sent1_q;
    logic [31:0] lfsr_state;
    int          addr_errors;
    int          exc_errors;
    int          other_errors;

    mmu_top dut0 (.*);

    always #20 clk = ~clk;

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return r;
    endfunction

    // Small page pool so that several entries can share a page
    function automatic tlb_entry_t random_entry();
        tlb_entry_t ent;
        ent.vppn = {3'(rand_bits(3)), 14'h0, 3'(rand_bits(3))};
        ent.asid = 10'(rand_bits(2));
        ent.g    = (rand_bits(2) == 32'd0);
        ent.e    = (rand_bits(4) != 32'd0);
        ent.ppn  = 20'(rand_bits(20));
        ent.plv  = 2'(rand_bits(2));
        ent.v    = (rand_bits(3) != 32'd0);
        ent.d    = (rand_bits(1) != 32'd0);
        return ent;
    endfunction

    function automatic logic [31:0] pick_vaddr(input logic [tlb_idx_w-1:0] idx);
        if (rand_bits(2) == 32'd0) begin
            return rand_bits(32);
        end
        return {model_tlb[idx].vppn, 12'(rand_bits(12))};
    endfunction

    function automatic mem_type_t pick_mem_type();
        logic [1:0] k;
        k = 2'(rand_bits(2));
        if (k == 2'd3) begin
            k = 2'd2;
        end
        return mem_type_t'(k);
    endfunction

    // Expected translation of one request under the current configuration
    function automatic result_t model_translate(input logic port1, input logic [31:0] vaddr,
                                                input mem_type_t mt, input plv_t plv);
        result_t    r;
        tlb_entry_t ent;
        logic       found;
        logic       win0;
        logic       win1;
        win0 = (dmw0_vseg == vaddr[31:29])
               && ((plv == 2'd0 && dmw0_plv0) || (plv == 2'd3 && dmw0_plv3));
        win1 = (dmw1_vseg == vaddr[31:29])
               && ((plv == 2'd0 && dmw1_plv0) || (plv == 2'd3 && dmw1_plv3));
        found = 1'b0;
        ent = '0;
        for (int i = 0; i < tlb_num; i++) begin
            if (!found && model_tlb[i].e && model_tlb[i].vppn == vaddr[31:12]
                && (model_tlb[i].g || model_tlb[i].asid == asid)) begin
                found = 1'b1;
                ent = model_tlb[i];
            end
        end
        r.exc = exc_none;
        if (!pg) begin
            r.paddr = vaddr;
        end else if (win0) begin
            r.paddr = {dmw0_pseg, vaddr[28:0]};
        end else if (win1) begin
            r.paddr = {dmw1_pseg, vaddr[28:0]};
        end else begin
            r.paddr = {ent.ppn, vaddr[11:0]};
            if (plv == 2'd3 && vaddr[31]) begin
                r.exc = port1 ? exc_adem : exc_adef;
            end else if (!found) begin
                r.exc = exc_tlbr;
            end else if (!ent.v) begin
                r.exc = (mt == mem_fetch) ? exc_pif : (mt == mem_store) ? exc_pis : exc_pil;
            end else if (plv > ent.plv) begin
                r.exc = exc_ppi;
            end else if (mt == mem_store && !ent.d) begin
                r.exc = exc_pme;
            end
        end
        return r;
    endfunction

    task automatic compare_addr(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            addr_errors++;
            $display("error %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_exc(input string name, input exc_code_t got, input exc_code_t exp);
        if (got !== exp) begin
            exc_errors++;
            $display("error %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Address only matters when no exception is expected
    task automatic check_result(input string name, input logic [31:0] paddr,
                                input exc_code_t exc, input result_t exp);
        compare_exc({name, "_exception"}, exc, exp.exc);
        if (exp.exc == exc_none) begin
            compare_addr({name, "_paddr"}, paddr, exp.paddr);
        end
    endtask

    // Requests seen by the DUT one cycle ago
    always @(posedge clk) begin
        if (reset) begin
            sent0_q <= 1'b0;
            sent1_q <= 1'b0;
        end else begin
            sent0_q <= s0_req;
            sent1_q <= s1_req;
        end
    end

    always @(negedge clk) begin : check_outputs
        result_t exp0;
        result_t exp1;
        if (s0_valid !== sent0_q || s1_valid !== sent1_q) begin
            other_errors++;
            $display("valid pulse at %0t does not match the requests one cycle earlier", $time);
        end
        if (s0_valid === 1'b1) begin
            if (exp_q0.size() == 0) begin
                other_errors++;
                $display("port 0 returned a result at %0t with nothing pending", $time);
            end else begin
                exp0 = exp_q0.pop_front();
                check_result("s0", s0_paddr, s0_exception, exp0);
            end
        end
        if (s1_valid === 1'b1) begin
            if (exp_q1.size() == 0) begin
                other_errors++;
                $display("port 1 returned a result at %0t with nothing pending", $time);
            end else begin
                exp1 = exp_q1.pop_front();
                check_result("s1", s1_paddr, s1_exception, exp1);
            end
        end
    end

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while ((reset || s0_valid !== 1'b0 || s1_valid !== 1'b0) && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 10) begin
            other_errors++;
            $display("reset did not release or valid outputs stayed high after reset");
        end
    endtask

    task automatic configure(input logic windows_on, input logic pg_random);
        @(posedge clk);
        s0_req    <= 1'b0;
        s1_req    <= 1'b0;
        tlb_we    <= 1'b0;
        asid      <= 10'(rand_bits(2));
        pg        <= pg_random ? (rand_bits(2) != 32'd0) : 1'b1;
        dmw0_plv0 <= windows_on && (rand_bits(1) != 32'd0);
        dmw0_plv3 <= windows_on && (rand_bits(1) != 32'd0);
        dmw1_plv0 <= windows_on && (rand_bits(1) != 32'd0);
        dmw1_plv3 <= windows_on && (rand_bits(1) != 32'd0);
        dmw0_vseg <= 3'(rand_bits(3));
        dmw0_pseg <= 3'(rand_bits(3));
        dmw1_vseg <= 3'(rand_bits(3));
        dmw1_pseg <= 3'(rand_bits(3));
    endtask

    task automatic write_entry(input logic [tlb_idx_w-1:0] idx, input tlb_entry_t ent);
        @(posedge clk);
        model_tlb[idx] = ent;
        s0_req     <= 1'b0;
        s1_req     <= 1'b0;
        tlb_we     <= 1'b1;
        tlb_windex <= idx;
        tlb_wentry <= ent;
    endtask

    task automatic random_cycle();
        logic [tlb_idx_w-1:0] idx0;
        logic [tlb_idx_w-1:0] wi;
        logic [31:0]          va0;
        logic [31:0]          va1;
        mem_type_t            mt0;
        mem_type_t            mt1;
        plv_t                 pl0;
        plv_t                 pl1;
        logic                 rq0;
        logic                 rq1;
        logic                 we;
        tlb_entry_t           ent;
        @(posedge clk);
        idx0 = tlb_idx_w'(rand_bits(4));
        rq0  = (rand_bits(3) != 32'd0);
        rq1  = (rand_bits(3) != 32'd0);
        va0  = pick_vaddr(idx0);
        va1  = pick_vaddr(tlb_idx_w'(rand_bits(4)));
        mt0  = pick_mem_type();
        mt1  = pick_mem_type();
        pl0  = 2'(rand_bits(2));
        pl1  = 2'(rand_bits(2));
        we   = (rand_bits(3) == 32'd0);
        // Often overwrite the very entry port 0 is searching
        wi   = (rand_bits(1) != 32'd0) ? idx0 : tlb_idx_w'(rand_bits(4));
        ent  = random_entry();
        if (rq0) begin
            exp_q0.push_back(model_translate(1'b0, va0, mt0, pl0));
        end
        if (rq1) begin
            exp_q1.push_back(model_translate(1'b1, va1, mt1, pl1));
        end
        // Write lands after the search of this cycle
        if (we) begin
            model_tlb[wi] = ent;
        end
        s0_req      <= rq0;
        s0_vaddr    <= va0;
        s0_mem_type <= mt0;
        s0_plv      <= pl0;
        s1_req      <= rq1;
        s1_vaddr    <= va1;
        s1_mem_type <= mt1;
        s1_plv      <= pl1;
        tlb_we      <= we;
        tlb_windex  <= wi;
        tlb_wentry  <= ent;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        s0_req <= 1'b0;
        s1_req <= 1'b0;
        tlb_we <= 1'b0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            other_errors++;
            $display("timed out with %0d results still missing", exp_q0.size() + exp_q1.size());
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        pg = 1'b1;
        asid = '0;
        dmw0_plv0 = 1'b0;
        dmw0_plv3 = 1'b0;
        dmw0_vseg = '0;
        dmw0_pseg = '0;
        dmw1_plv0 = 1'b0;
        dmw1_plv3 = 1'b0;
        dmw1_vseg = '0;
        dmw1_pseg = '0;
        tlb_we = 1'b0;
        tlb_windex = '0;
        tlb_wentry = '0;
        // Requests while in reset must not produce a result
        s0_req = 1'b1;
        s0_vaddr = '0;
        s0_mem_type = mem_load;
        s0_plv = '0;
        s1_req = 1'b1;
        s1_vaddr = '0;
        s1_mem_type = mem_load;
        s1_plv = '0;
        lfsr_state = 32'ha4d4576a;
        addr_errors = 0;
        exc_errors = 0;
        other_errors = 0;
        for (int i = 0; i < tlb_num; i++) begin
            model_tlb[i] = '0;
        end

        @(posedge clk);
        s0_req <= 1'b0;
        s1_req <= 1'b0;
        @(posedge clk);
        reset <= 1'b0;
        wait_reset_release();

        // Paging only with the windows off
        configure(1'b0, 1'b0);
        for (int i = 0; i < tlb_num; i++) begin
            write_entry(tlb_idx_w'(i), random_entry());
        end
        for (int n = 0; n < 300; n++) begin
            if (n % 32 == 0) begin
                configure(1'b0, 1'b0);
            end
            random_cycle();
        end

        // Windows and direct translation mixed in
        for (int n = 0; n < 300; n++) begin
            if (n % 8 == 0) begin
                configure(1'b1, 1'b1);
            end
            random_cycle();
        end
        drain();

        $display("errors: address %0d, exception %0d, other %0d",
                 addr_errors, exc_errors, other_errors);
        if (addr_errors + exc_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tlb_exp_handler.sv
`timescale 1ns/1ps

module tlb_exp_handler (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pg,
    input  logic                  s0_req,
    input  logic                  s1_req,
    input  logic [31:0]           s0_vaddr,
    input  logic [31:0]           s1_vaddr,
    input  mmu_pkg::mem_type_t    s0_mem_type,
    input  mmu_pkg::mem_type_t    s1_mem_type,
    input  mmu_pkg::plv_t         s0_plv,
    input  mmu_pkg::plv_t         s1_plv,
    tlb_search_if.sink            s0_tlb,
    tlb_search_if.sink            s1_tlb,
    input  logic                  s0_dmw_hit,
    input  logic                  s1_dmw_hit,
    input  logic [31:0]           s0_dmw_paddr,
    input  logic [31:0]           s1_dmw_paddr,
    output logic                  s0_valid,
    output logic                  s1_valid,
    output logic [31:0]           s0_paddr,
    output logic [31:0]           s1_paddr,
    output exc_pkg::exc_code_t    s0_exception,
    output exc_pkg::exc_code_t    s1_exception
);

    import mmu_pkg::*;
    import exc_pkg::*;

    exc_code_t   s0_exc_c;
    exc_code_t   s1_exc_c;
    logic [31:0] s0_paddr_c;
    logic [31:0] s1_paddr_c;

    // Priority chain, ade_code differs between fetch and memory ports
    function automatic exc_code_t exc_sel(
        input exc_code_t   ade_code,
        input plv_t        plv,
        input logic [31:0] vaddr,
        input mem_type_t   mem_type,
        input logic        found,
        input logic        v,
        input logic        d,
        input plv_t        page_plv
    );
        exc_code_t code;
        code = exc_none;
        if (plv == plv_user && vaddr[31]) begin
            code = ade_code;
        end else if (!found) begin
            code = exc_tlbr;
        end else if (!v) begin
            case (mem_type)
                mem_fetch: code = exc_pif;
                mem_load:  code = exc_pil;
                mem_store: code = exc_pis;
                default:   code = exc_none;
            endcase
        end else if (plv > page_plv) begin
            code = exc_ppi;
        end else if (mem_type == mem_store && !d) begin
            code = exc_pme;
        end
        return code;
    endfunction

    // Windows and direct translation never fault
    assign s0_exc_c = (pg && !s0_dmw_hit) ? exc_sel(exc_adef, s0_plv, s0_vaddr, s0_mem_type,
        s0_tlb.found, s0_tlb.v, s0_tlb.d, s0_tlb.plv) : exc_none;
    assign s1_exc_c = (pg && !s1_dmw_hit) ? exc_sel(exc_adem, s1_plv, s1_vaddr, s1_mem_type,
        s1_tlb.found, s1_tlb.v, s1_tlb.d, s1_tlb.plv) : exc_none;

    // Direct, window or page translation
    assign s0_paddr_c = !pg ? s0_vaddr : s0_dmw_hit ? s0_dmw_paddr : {s0_tlb.ppn, s0_vaddr[11:0]};
    assign s1_paddr_c = !pg ? s1_vaddr : s1_dmw_hit ? s1_dmw_paddr : {s1_tlb.ppn, s1_vaddr[11:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
        end else begin
            s0_valid <= s0_req;
            s1_valid <= s1_req;
        end
    end

    // Result payload, captured with the request
    always_ff @(posedge clk) begin
        if (s0_req) begin
            s0_paddr     <= s0_paddr_c;
            s0_exception <= s0_exc_c;
        end
        if (s1_req) begin
            s1_paddr     <= s1_paddr_c;
            s1_exception <= s1_exc_c;
        end
    end

endmodule

// File: tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         tlb_we,
    input  logic [mmu_pkg::tlb_idx_w-1:0] tlb_windex,
    input  mmu_pkg::tlb_entry_t          tlb_wentry,
    input  mmu_pkg::asid_t               asid,
    input  mmu_pkg::vppn_t               s0_vppn,
    input  mmu_pkg::vppn_t               s1_vppn,
    tlb_search_if.source                 s0_res,
    tlb_search_if.source                 s1_res
);

    import mmu_pkg::*;

    tlb_entry_t entries [tlb_num];

    logic [tlb_num-1:0]   s0_hits;
    logic [tlb_num-1:0]   s1_hits;
    logic [tlb_idx_w-1:0] s0_idx;
    logic [tlb_idx_w-1:0] s1_idx;

    // Only the exist bits are cleared, the rest is don't care until written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_num; i++) begin
                entries[i].e <= 1'b0;
            end
        end else if (tlb_we) begin
            entries[tlb_windex] <= tlb_wentry;
        end
    end

    // Match vector for one virtual page, global entries ignore the ASID
    function automatic logic [tlb_num-1:0] hit_vec(input vppn_t vppn);
        logic [tlb_num-1:0] hits;
        hits = '0;
        for (int i = 0; i < tlb_num; i++) begin
            hits[i] = entries[i].e && (entries[i].vppn == vppn)
                      && (entries[i].g || (entries[i].asid == asid));
        end
        return hits;
    endfunction

    // Lowest matching index wins
    function automatic logic [tlb_idx_w-1:0] first_idx(input logic [tlb_num-1:0] hits);
        logic [tlb_idx_w-1:0] idx;
        idx = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (hits[i]) begin
                idx = tlb_idx_w'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        s0_hits = hit_vec(s0_vppn);
        s1_hits = hit_vec(s1_vppn);
        s0_idx  = first_idx(s0_hits);
        s1_idx  = first_idx(s1_hits);
    end

    // Port 0 result
    assign s0_res.found = |s0_hits;
    assign s0_res.ppn   = entries[s0_idx].ppn;
    assign s0_res.plv   = entries[s0_idx].plv;
    assign s0_res.v     = entries[s0_idx].v;
    assign s0_res.d     = entries[s0_idx].d;

    // Port 1 result
    assign s1_res.found = |s1_hits;
    assign s1_res.ppn   = entries[s1_idx].ppn;
    assign s1_res.plv   = entries[s1_idx].plv;
    assign s1_res.v     = entries[s1_idx].v;
    assign s1_res.d     = entries[s1_idx].d;

endmodule

// File: tlb_search_if.sv
`timescale 1ns/1ps

interface tlb_search_if;

    import mmu_pkg::*;

    // Search result of one port
    logic found;
    ppn_t ppn;
    plv_t plv;
    logic v;
    logic d;

    modport source (
        output found,
        output ppn,
        output plv,
        output v,
        output d
    );

    modport sink (
        input found,
        input ppn,
        input plv,
        input v,
        input d
    );

endinterface
